/* rtl/uart_pkg.sv */
// Shared UART register map, field structs and RX FIFO entry; divisor is fixed at 16 bits
package uart_pkg;

  // Word addresses on the 3-bit ADR_I
  localparam logic [2:0] addr_txdata = 3'd0;
  localparam logic [2:0] addr_rxdata = 3'd1;
  localparam logic [2:0] addr_txctrl = 3'd2;
  localparam logic [2:0] addr_rxctrl = 3'd3;
  localparam logic [2:0] addr_ie     = 3'd4;
  localparam logic [2:0] addr_ip     = 3'd5;
  localparam logic [2:0] addr_div    = 3'd6;

  localparam int div_width = 16;

  // txctrl fields, bus bits 18:16, 1 and 0
  typedef struct packed {
    logic [2:0] txcnt;
    logic       nstop;
    logic       txen;
  } tx_ctrl_t;

  // rxctrl fields, bus bits 18:16 and 0
  typedef struct packed {
    logic [2:0] rxcnt;
    logic       rxen;
  } rx_ctrl_t;

  // Configuration seen by the datapath blocks
  typedef struct packed {
    tx_ctrl_t             tx;
    rx_ctrl_t             rx;
    logic [div_width-1:0] div;
  } uart_cfg_t;

  // One received character
  typedef struct packed {
    logic       frame_err;
    logic [7:0] data;
  } rx_word_t;

endpackage

/* rtl/uart_fifo.sv */
// Show-ahead FIFO for any payload type; DEPTH must be a power of two, full push and empty pop ignored
module uart_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 8
) (
  input  logic                       CLK_I,
  input  logic                       RST_I,
  input  logic                       push,
  input  payload_t                   wdata,
  input  logic                       pop,
  output payload_t                   rdata,
  output logic                       full,
  output logic                       empty,
  output logic [$clog2(DEPTH+1)-1:0] level
);

  localparam int ptr_w = $clog2(DEPTH);
  localparam int lvl_w = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign full    = (level == lvl_w'(DEPTH));
  assign empty   = (level == '0);
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // Head entry is always visible
  assign rdata = mem[rd_ptr];

  always_ff @(posedge CLK_I) begin
    if (do_push) mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + ptr_w'(1);
      if (do_pop) rd_ptr <= rd_ptr + ptr_w'(1);
      // Simultaneous push and pop leave the level unchanged
      case ({do_push, do_pop})
        2'b10:   level <= level + lvl_w'(1);
        2'b01:   level <= level - lvl_w'(1);
        default: level <= level;
      endcase
    end
  end

endmodule

/* rtl/uart_baud_gen.sv */
// Bit and 16x oversample tick generator; exact 16x ratio only when div+1 is a multiple of 16
module uart_baud_gen (
  input  logic                          CLK_I,
  input  logic                          RST_I,
  input  logic [uart_pkg::div_width-1:0] div,
  output logic                          bit_tick,
  output logic                          os_tick
);

  localparam int os_w = uart_pkg::div_width - 4;

  logic [uart_pkg::div_width-1:0] div_q;
  logic [uart_pkg::div_width-1:0] bit_cnt;
  logic [os_w-1:0]                os_cnt;

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      div_q    <= '0;
      bit_cnt  <= '0;
      os_cnt   <= '0;
      bit_tick <= 1'b0;
      os_tick  <= 1'b0;
    end else if (div != div_q) begin
      // New divisor restarts both periods
      div_q    <= div;
      bit_cnt  <= '0;
      os_cnt   <= '0;
      bit_tick <= 1'b0;
      os_tick  <= 1'b0;
    end else begin
      bit_tick <= (bit_cnt == div_q);
      os_tick  <= (os_cnt == div_q[uart_pkg::div_width-1:4]);
      if (bit_cnt == div_q) bit_cnt <= '0;
      else bit_cnt <= bit_cnt + 1'b1;
      // Oversample period is (div >> 4) + 1
      if (os_cnt == div_q[uart_pkg::div_width-1:4]) os_cnt <= '0;
      else os_cnt <= os_cnt + 1'b1;
    end
  end

endmodule

/* rtl/uart_tx.sv */
// Serial transmitter, 8N1 or 8N2 LSB first; a frame starts on the bit tick after the FIFO pop
module uart_tx (
  input  logic                CLK_I,
  input  logic                RST_I,
  input  uart_pkg::uart_cfg_t cfg,
  input  logic                bit_tick,
  input  logic                fifo_empty,
  input  logic [7:0]          fifo_data,
  output logic                pop,
  output logic                txd
);

  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_data,
    st_stop1,
    st_stop2
  } tx_state_t;

  tx_state_t  state;
  logic       loaded;
  logic [2:0] bit_cnt;
  logic [7:0] shift;

  assign pop = (state == st_idle) & ~loaded & cfg.tx.txen & ~fifo_empty;

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      state   <= st_idle;
      loaded  <= 1'b0;
      bit_cnt <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (pop) begin
            loaded <= 1'b1;
          end else if (loaded && bit_tick) begin
            loaded <= 1'b0;
            state  <= st_start;
          end
        end
        st_start: begin
          if (bit_tick) begin
            bit_cnt <= '0;
            state   <= st_data;
          end
        end
        st_data: begin
          if (bit_tick) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) state <= st_stop1;
          end
        end
        st_stop1: if (bit_tick) state <= cfg.tx.nstop ? st_stop2 : st_idle;
        st_stop2: if (bit_tick) state <= st_idle;
        default:  state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge CLK_I) begin
    if (pop) shift <= fifo_data;
    else if (state == st_data && bit_tick) shift <= {1'b0, shift[7:1]};
  end

  // Line level follows the state, high in idle and stop bits
  always_comb begin
    case (state)
      st_start: txd = 1'b0;
      st_data:  txd = shift[0];
      default:  txd = 1'b1;
    endcase
  end

endmodule

/* rtl/uart_rx.sv */
// 16x oversampling receiver; checks the first stop bit only, frames arriving at a full FIFO are lost
module uart_rx (
  input  logic                CLK_I,
  input  logic                RST_I,
  input  uart_pkg::uart_cfg_t cfg,
  input  logic                os_tick,
  input  logic                rxd,
  output logic                push,
  output uart_pkg::rx_word_t  wdata
);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } rx_state_t;

  rx_state_t  state;
  logic [1:0] sync;
  logic       rxd_s;
  logic       rxd_d;
  logic [3:0] os_cnt;
  logic [2:0] bit_cnt;
  logic [7:0] shift;
  logic       bit_done;

  assign rxd_s = sync[1];
  // Mid-bit point of data and stop bits
  assign bit_done = os_tick & (os_cnt == 4'd15);

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      sync    <= 2'b11;
      rxd_d   <= 1'b1;
      state   <= st_idle;
      os_cnt  <= '0;
      bit_cnt <= '0;
      push    <= 1'b0;
    end else begin
      sync  <= {sync[0], rxd};
      rxd_d <= rxd_s;
      push  <= 1'b0;
      case (state)
        st_idle: begin
          if (cfg.rx.rxen && rxd_d && !rxd_s) begin
            os_cnt <= '0;
            state  <= st_start;
          end
        end
        st_start: begin
          if (os_tick) begin
            if (os_cnt == 4'd7) begin
              os_cnt  <= '0;
              bit_cnt <= '0;
              // High at mid start bit is a glitch
              state   <= rxd_s ? st_idle : st_data;
            end else begin
              os_cnt <= os_cnt + 4'd1;
            end
          end
        end
        st_data: begin
          if (os_tick) os_cnt <= os_cnt + 4'd1;
          if (bit_done) begin
            bit_cnt <= bit_cnt + 3'd1;
            if (bit_cnt == 3'd7) state <= st_stop;
          end
        end
        st_stop: begin
          if (os_tick) os_cnt <= os_cnt + 4'd1;
          if (bit_done) begin
            push  <= 1'b1;
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge CLK_I) begin
    if (state == st_data && bit_done) shift <= {rxd_s, shift[7:1]};
    if (state == st_stop && bit_done) begin
      wdata.data      <= shift;
      wdata.frame_err <= ~rxd_s;
    end
  end

endmodule

/* rtl/uart_regs.sv */
// Bus slave with fixed one-cycle ACK_O; side effects and DAT_O capture happen on the ACK edge
module uart_regs #(
  parameter logic [uart_pkg::div_width-1:0] DIV_RESET = 16'd86,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                          CLK_I,
  input  logic                          RST_I,
  input  logic                          CYC_I,
  input  logic                          STB_I,
  input  logic                          WE_I,
  input  logic [2:0]                    ADR_I,
  input  logic [31:0]                   DAT_I,
  output logic [31:0]                   DAT_O,
  output logic                          ACK_O,
  output uart_pkg::uart_cfg_t           cfg,
  output logic                          tx_push,
  output logic [7:0]                    tx_wdata,
  output logic                          rx_pop,
  output logic                          irq,
  input  logic                          tx_full,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0] tx_level,
  input  logic                          rx_empty,
  input  uart_pkg::rx_word_t            rx_rdata,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0] rx_level
);

  localparam int lvl_w = $clog2(FIFO_DEPTH + 1);

  logic        access;
  logic        wr_acc;
  logic [1:0]  ie;
  logic        txwm_p;
  logic        rxwm_p;
  logic [31:0] rd_word;

  // A new request is acknowledged on the next edge, never twice in a row
  assign access = CYC_I & STB_I & ~ACK_O;
  assign wr_acc = access & WE_I;

  assign tx_push  = wr_acc & (ADR_I == uart_pkg::addr_txdata) & ~tx_full;
  assign tx_wdata = DAT_I[7:0];
  assign rx_pop   = access & ~WE_I & (ADR_I == uart_pkg::addr_rxdata) & ~rx_empty;

  // Watermark pending bits
  assign txwm_p = (tx_level < lvl_w'(cfg.tx.txcnt)) & ie[0];
  assign rxwm_p = (rx_level > lvl_w'(cfg.rx.rxcnt)) & ie[1];
  assign irq    = txwm_p | rxwm_p;

  always_comb begin
    rd_word = '0;
    case (ADR_I)
      uart_pkg::addr_txdata: rd_word[31] = tx_full;
      uart_pkg::addr_rxdata: begin
        rd_word[31] = rx_empty;
        if (!rx_empty) rd_word[8:0] = rx_rdata;
      end
      uart_pkg::addr_txctrl: begin
        rd_word[18:16] = cfg.tx.txcnt;
        rd_word[1]     = cfg.tx.nstop;
        rd_word[0]     = cfg.tx.txen;
      end
      uart_pkg::addr_rxctrl: begin
        rd_word[18:16] = cfg.rx.rxcnt;
        rd_word[0]     = cfg.rx.rxen;
      end
      uart_pkg::addr_ie:  rd_word[1:0] = ie;
      uart_pkg::addr_ip:  rd_word[1:0] = {rxwm_p, txwm_p};
      uart_pkg::addr_div: rd_word[uart_pkg::div_width-1:0] = cfg.div;
      default: rd_word = '0;
    endcase
  end

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      ACK_O   <= 1'b0;
      DAT_O   <= '0;
      ie      <= '0;
      cfg.tx  <= '0;
      cfg.rx  <= '0;
      cfg.div <= DIV_RESET;
    end else begin
      ACK_O <= access;
      // Read data is taken before the pop moves the RX FIFO
      if (access) DAT_O <= WE_I ? 32'd0 : rd_word;
      if (wr_acc) begin
        case (ADR_I)
          uart_pkg::addr_txctrl: begin
            cfg.tx.txcnt <= DAT_I[18:16];
            cfg.tx.nstop <= DAT_I[1];
            cfg.tx.txen  <= DAT_I[0];
          end
          uart_pkg::addr_rxctrl: begin
            cfg.rx.rxcnt <= DAT_I[18:16];
            cfg.rx.rxen  <= DAT_I[0];
          end
          uart_pkg::addr_ie:  ie <= DAT_I[1:0];
          uart_pkg::addr_div: cfg.div <= DAT_I[uart_pkg::div_width-1:0];
          default: ;
        endcase
      end
    end
  end

endmodule

/* rtl/uart_top.sv */
// FE310-style UART without parity; reset divisor is CLK_FREQ_HZ/BAUD-1 and must fit in 16 bits
module uart_top #(
  parameter int CLK_FREQ_HZ = 10_000_000,
  parameter int BAUD        = 115_200
) (
  input  logic        CLK_I,
  input  logic        RST_I,
  input  logic        CYC_I,
  input  logic        STB_I,
  input  logic        WE_I,
  input  logic [2:0]  ADR_I,
  input  logic [31:0] DAT_I,
  output logic [31:0] DAT_O,
  output logic        ACK_O,
  output logic        irq,
  input  logic        rxd,
  output logic        txd
);

  localparam int FIFO_DEPTH = 8;
  localparam int div_full   = CLK_FREQ_HZ / BAUD - 1;
  localparam logic [uart_pkg::div_width-1:0] DIV_RESET = div_full[uart_pkg::div_width-1:0];
  localparam int lvl_w = $clog2(FIFO_DEPTH + 1);

  uart_pkg::uart_cfg_t cfg;
  uart_pkg::rx_word_t  rx_wdata;
  uart_pkg::rx_word_t  rx_rdata;

  logic             tx_push;
  logic [7:0]       tx_wdata;
  logic             tx_pop;
  logic [7:0]       tx_rdata;
  logic             tx_full;
  logic             tx_empty;
  logic [lvl_w-1:0] tx_level;
  logic             rx_push;
  logic             rx_pop;
  logic             rx_empty;
  logic [lvl_w-1:0] rx_level;
  logic             bit_tick;
  logic             os_tick;

  uart_regs #(
    .DIV_RESET (DIV_RESET),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_regs (
    .CLK_I, .RST_I, .CYC_I, .STB_I, .WE_I, .ADR_I, .DAT_I, .DAT_O, .ACK_O,
    .cfg, .tx_push, .tx_wdata, .rx_pop, .irq,
    .tx_full, .tx_level, .rx_empty, .rx_rdata, .rx_level
  );

  uart_fifo #(.payload_t(logic [7:0]), .DEPTH(FIFO_DEPTH)) tx_fifo (
    .CLK_I, .RST_I, .push(tx_push), .wdata(tx_wdata), .pop(tx_pop),
    .rdata(tx_rdata), .full(tx_full), .empty(tx_empty), .level(tx_level)
  );

  // Full flag of the RX FIFO is only seen through the dropped push
  uart_fifo #(.payload_t(uart_pkg::rx_word_t), .DEPTH(FIFO_DEPTH)) rx_fifo (
    .CLK_I, .RST_I, .push(rx_push), .wdata(rx_wdata), .pop(rx_pop),
    .rdata(rx_rdata), .full(), .empty(rx_empty), .level(rx_level)
  );

  uart_baud_gen u_baud (.CLK_I, .RST_I, .div(cfg.div), .bit_tick, .os_tick);

  uart_tx u_tx (
    .CLK_I, .RST_I, .cfg, .bit_tick, .fifo_empty(tx_empty), .fifo_data(tx_rdata),
    .pop(tx_pop), .txd
  );

  uart_rx u_rx (.CLK_I, .RST_I, .cfg, .os_tick, .rxd, .push(rx_push), .wdata(rx_wdata));

endmodule

/* tb/uart_props.sv */
// Bus and idle-line assertions bound into uart_top; reads the transmitter state by hierarchy
module uart_props (
  input logic       CLK_I,
  input logic       RST_I,
  input logic       CYC_I,
  input logic       STB_I,
  input logic       ACK_O,
  input logic       txd,
  input logic       txen,
  input logic [2:0] tx_state,
  input logic       tx_loaded
);

  // Acknowledge is a single-cycle pulse
  ack_single: assert property (@(posedge CLK_I) disable iff (RST_I)
    ACK_O |=> !ACK_O)
    else $error("ACK_O stayed high for two cycles");

  ack_after_request: assert property (@(posedge CLK_I) disable iff (RST_I)
    (CYC_I && STB_I && !ACK_O) |=> ACK_O)
    else $error("request was not acknowledged on the next cycle");

  // State code 0 is the transmitter idle state
  // An idle transmitter with nothing loaded must not start a frame while txen is low
  idle_line_high: assert property (@(posedge CLK_I) disable iff (RST_I)
    $past(!txen && tx_state == 3'd0 && !tx_loaded, 2) |-> txd)
    else $error("txd left the idle level while the transmitter was disabled");

endmodule

bind uart_top uart_props u_props (
  .CLK_I    (CLK_I),
  .RST_I    (RST_I),
  .CYC_I    (CYC_I),
  .STB_I    (STB_I),
  .ACK_O    (ACK_O),
  .txd      (txd),
  .txen     (cfg.tx.txen),
  .tx_state (u_tx.state),
  .tx_loaded(u_tx.loaded)
);

/* tb/uart_tb.sv */
// Trace-driven UART testbench; run from the project root, expects DIV_RESET of 86 and 8-deep FIFOs
module uart_tb;

  localparam int clk_freq_hz = 10_022_400;
  localparam int baud        = 115_200;
  localparam int bus_timeout = 16;
  localparam int rx_wait_bits = 24;

  logic        CLK_I = 1'b0;
  logic        RST_I;
  logic        CYC_I;
  logic        STB_I;
  logic        WE_I;
  logic [2:0]  ADR_I;
  logic [31:0] DAT_I;
  logic [31:0] DAT_O;
  logic        ACK_O;
  logic        irq;
  logic        rxd;
  logic        txd;
  logic        loopback;
  logic        rxd_drv;

  int          cur_div;
  int          max_div;
  int          test_num;
  int          test_err;
  int          n_pass;
  int          n_fail;
  longint      wd_limit;
  logic        trace_ready;
  byte         op_q[$];
  logic [31:0] a_q[$];
  logic [31:0] b_q[$];
  logic [31:0] c_q[$];

  // Serial loopback switch
  assign rxd = loopback ? txd : rxd_drv;

  uart_top #(.CLK_FREQ_HZ(clk_freq_hz), .BAUD(baud)) dut (
    .CLK_I, .RST_I, .CYC_I, .STB_I, .WE_I, .ADR_I, .DAT_I, .DAT_O, .ACK_O,
    .irq, .rxd, .txd
  );

  always #4 CLK_I = ~CLK_I;

  function automatic int load_trace();
    int          fd;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    fd = $fopen("tb/uart_trace.txt", "r");
    if (fd == 0) return 0;
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      a = '0;
      b = '0;
      c = '0;
      void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h", a, b, c));
      op_q.push_back(line.getc(0));
      a_q.push_back(a);
      b_q.push_back(b);
      c_q.push_back(c);
      // Largest divisor sets the watchdog
      if (line.getc(0) == "W" && a[2:0] == 3'd6 && int'(b[15:0]) > max_div)
        max_div = int'(b[15:0]);
    end
    $fclose(fd);
    return 1;
  endfunction

  task automatic bus_access(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rdata);
    int n;
    n = 0;
    CYC_I = 1'b1;
    STB_I = 1'b1;
    WE_I  = we;
    ADR_I = adr;
    DAT_I = wdata;
    do begin
      @(posedge CLK_I);
      #1;
      n++;
    end while (!ACK_O && n < bus_timeout);
    rdata = DAT_O;
    assert (ACK_O) else begin
      $display("Bus access to address %0d got no acknowledge", adr);
      test_err++;
    end
    CYC_I = 1'b0;
    STB_I = 1'b0;
    WE_I  = 1'b0;
  endtask

  task automatic drive_bit(input logic v);
    rxd_drv = v;
    repeat (cur_div + 1) @(posedge CLK_I);
    #1;
  endtask

  // Start bit, data LSB first, stop bit at the given level, one idle bit
  task automatic force_serial(input logic [7:0] data, input logic stop);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) drive_bit(data[i]);
    drive_bit(stop);
    drive_bit(1'b1);
  endtask

  // rx_empty is the source of the rxdata empty bit, watched without popping
  task automatic wait_rx_byte();
    int n;
    n = 0;
    while (dut.rx_empty && n < rx_wait_bits * (cur_div + 1)) begin
      @(posedge CLK_I);
      #1;
      n++;
    end
    assert (!dut.rx_empty) else begin
      $display("No byte arrived at the receiver within %0d cycles", n);
      test_err++;
    end
  endtask

  task automatic wait_irq(input logic level, input int bits);
    int n;
    n = 0;
    while (irq !== level && n < bits * (cur_div + 1)) begin
      @(posedge CLK_I);
      #1;
      n++;
    end
    assert (irq === level) else begin
      $display("irq did not reach level %0b within %0d cycles", level, n);
      test_err++;
    end
  endtask

  task automatic report_test();
    if (test_err == 0) begin
      n_pass++;
      $display("Test %0d finished, no errors", test_num);
    end else begin
      n_fail++;
      $display("Test %0d finished with %0d errors", test_num, test_err);
    end
  endtask

  task automatic run_trace();
    logic [31:0] rd;
    for (int i = 0; i < op_q.size(); i++) begin
      case (op_q[i])
        "T": begin
          test_num = int'(a_q[i]);
          test_err = 0;
        end
        "W": begin
          bus_access(1'b1, a_q[i][2:0], b_q[i], rd);
          if (a_q[i][2:0] == 3'd6) cur_div = int'(b_q[i][15:0]);
        end
        "R": begin
          bus_access(1'b0, a_q[i][2:0], 32'd0, rd);
          assert (((rd ^ b_q[i]) & c_q[i]) == 32'd0) else begin
            $display("[FAIL] %0t: address %0d expected %08h actual %08h mask %08h",
                     $time, a_q[i][2:0], b_q[i], rd, c_q[i]);
            test_err++;
          end
        end
        "S": force_serial(a_q[i][7:0], b_q[i][0]);
        "L": loopback = a_q[i][0];
        "E": wait_rx_byte();
        "I": begin
          assert (irq === a_q[i][0]) else begin
            $display("[FAIL] %0t: irq expected %0b actual %0b", $time, a_q[i][0], irq);
            test_err++;
          end
        end
        "Q": wait_irq(a_q[i][0], int'(b_q[i]));
        "X": report_test();
        default: begin
          $display("Unknown trace operation on entry %0d", i);
          test_err++;
        end
      endcase
    end
  endtask

  initial begin
    int ok;
    RST_I       = 1'b1;
    CYC_I       = 1'b0;
    STB_I       = 1'b0;
    WE_I        = 1'b0;
    ADR_I       = '0;
    DAT_I       = '0;
    loopback    = 1'b0;
    rxd_drv     = 1'b1;
    cur_div     = 86;
    max_div     = 86;
    n_pass      = 0;
    n_fail      = 0;
    test_err    = 0;
    trace_ready = 1'b0;
    ok = load_trace();
    if (ok == 0) begin
      $display("Could not open the trace file tb/uart_trace.txt");
      $display("Verification failed");
      $finish;
    end else begin
      wd_limit = longint'(op_q.size()) * 12 * (max_div + 1) * 8;
      trace_ready = 1'b1;
      repeat (8) @(posedge CLK_I);
      #1;
      RST_I = 1'b0;
      run_trace();
      $display("Tests passed: %0d, tests failed: %0d", n_pass, n_fail);
      if (n_fail == 0 && n_pass > 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
      $finish;
    end
  end

  // Watchdog sized from the trace length
  initial begin
    wait (trace_ready);
    #(wd_limit);
    $display("Timeout: the run exceeded %0d time units", wd_limit);
    $display("Verification failed");
    $finish;
  end

endmodule

/* files.f */
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_baud_gen.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_regs.sv
rtl/uart_top.sv
tb/uart_props.sv
tb/uart_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module uart_tb -o uart_sim

# The simulator exits non-zero on assertion errors, the log decides the result
./obj_dir/uart_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Verification passed" sim.log; then
  exit 0
fi
exit 1

/* tb/uart_trace.txt */
# op letter, then up to three hex fields: T num | W addr data | R addr expected mask
# S byte stop | L on | E (wait for a byte) | I irq | Q irq bit_periods | X (test end)
T 1
R 6 00000056 ffffffff
R 2 00000000 ffffffff
R 3 00000000 ffffffff
R 4 00000000 ffffffff
R 5 00000000 ffffffff
R 1 80000000 ffffffff
R 0 00000000 ffffffff
I 0
X
T 2
W 2 ffffffff
R 2 00070003 ffffffff
W 3 ffffffff
R 3 00070001 ffffffff
W 4 ffffffff
R 4 00000003 ffffffff
W 6 ffff00c7
R 6 000000c7 ffffffff
R 7 00000000 ffffffff
X
T 3
W 6 0000001f
W 4 00000002
W 3 00030001
W 2 00000001
L 1
W 0 000000a5
W 0 0000003c
W 0 000000ff
W 0 00000000
Q 1 40
R 1 000000a5 800001ff
R 1 0000003c 800001ff
R 1 000000ff 800001ff
R 1 00000000 800001ff
R 1 80000000 80000000
X
T 4
W 2 00000000
W 3 00070001
W 0 00000001
W 0 00000002
W 0 00000003
W 0 00000004
W 0 00000005
W 0 00000006
W 0 00000007
W 0 00000008
R 0 80000000 80000000
W 0 00000009
W 2 00000001
Q 1 c0
R 1 00000001 800001ff
R 1 00000002 800001ff
R 1 00000003 800001ff
R 1 00000004 800001ff
R 1 00000005 800001ff
R 1 00000006 800001ff
R 1 00000007 800001ff
R 1 00000008 800001ff
R 1 80000000 80000000
X
T 5
W 2 00020000
W 4 00000001
R 5 00000001 00000003
I 1
W 0 00000011
W 0 00000022
R 5 00000000 00000003
I 0
W 4 00000002
W 3 00010001
W 2 00020001
E
R 5 00000000 00000003
Q 1 30
R 5 00000002 00000003
R 1 00000011 800001ff
R 1 00000022 800001ff
R 5 00000000 00000003
X
T 6
L 0
S 5a 0
E
R 1 0000015a 800001ff
S 66 1
E
R 1 00000066 800001ff
R 1 80000000 80000000
X
